//--- Makefile
# Verilator build and run of the block buffer testbench

VERILATOR ?= verilator
TOP       ?= block_buffer_tb
SEED      ?= 99609
FILELIST  ?= block_buffer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Done: no errors

.PHONY: sim clean

# the run passes only if the pass message shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- block_buffer.f
hw/block_buffer_pkg.sv
hw/evt_counter.sv
hw/pipeliner.sv
hw/block_ram.sv
hw/block_store.sv
hw/req_ack_slave.sv
hw/block_buffer_top.sv
dv/block_buffer_tb.sv

//--- dv/block_buffer_tb.sv
`default_nettype none

module block_buffer_tb #(
    parameter int SEED = 99609
);

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int NUM_ROWS      = 12;
    localparam int NUM_RANDOM    = 48;
    localparam int CYCLES_PER_OP = 64;  // worst flush is about 40 cycles

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_FLUSH} op_kind_t;

    // one table row is repeated count times and its write data steps by one per repeat
    typedef struct packed {
        op_kind_t                      kind;
        int                            count;
        block_buffer_pkg::block_t      data;
        block_buffer_pkg::block_addr_t first_addr;  // address of the row's first response
    } op_entry_t;

    logic                          clk_in;
    logic                          rst_in;
    logic                          wr_req;
    block_buffer_pkg::block_t      wr_data;
    logic                          wr_ack;
    block_buffer_pkg::block_addr_t wr_addr;
    logic                          rd_req;
    logic                          rd_ack;
    block_buffer_pkg::read_rsp_t   rd_rsp;
    logic                          fl_req;
    logic                          fl_ack;
    logic                          flush_valid;
    block_buffer_pkg::flush_beat_t flush_beat;

    // reference model
    block_buffer_pkg::block_t      model_mem [block_buffer_pkg::NUM_BLOCKS];
    block_buffer_pkg::block_addr_t model_wr_ptr;
    block_buffer_pkg::block_addr_t model_rd_ptr;

    block_buffer_pkg::flush_beat_t beats [$];  // flush stream as seen on the bus

    op_entry_t op_table [NUM_ROWS] = '{
        '{OP_READ,   1, 32'h0000_0000, 4'd0},   // unwritten entry reads as zero
        '{OP_WRITE,  3, 32'h1000_0000, 4'd0},
        '{OP_READ,   3, 32'h0000_0000, 4'd1},
        '{OP_WRITE,  2, 32'h2000_0000, 4'd3},
        '{OP_FLUSH,  1, 32'h0000_0000, 4'd0},   // shift starts from address 4
        '{OP_READ,  16, 32'h0000_0000, 4'd0},   // full lap with the last flag at 15
        '{OP_WRITE, 13, 32'h3000_0000, 4'd5},   // wraps and overwrites 0 and 1
        '{OP_READ,   2, 32'h0000_0000, 4'd0},
        '{OP_FLUSH,  1, 32'h0000_0000, 4'd0},
        '{OP_READ,   1, 32'h0000_0000, 4'd0},   // pointer back at 0
        '{OP_WRITE,  1, 32'hDEAD_BEEF, 4'd2},
        '{OP_FLUSH,  1, 32'h0000_0000, 4'd0}
    };

    block_buffer_top DUT (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .wr_req      (wr_req),
        .wr_data     (wr_data),
        .wr_ack      (wr_ack),
        .wr_addr     (wr_addr),
        .rd_req      (rd_req),
        .rd_ack      (rd_ack),
        .rd_rsp      (rd_rsp),
        .fl_req      (fl_req),
        .fl_ack      (fl_ack),
        .flush_valid (flush_valid),
        .flush_beat  (flush_beat)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(negedge clk_in) begin
        if (!rst_in && flush_valid === 1'b1) begin
            beats.push_back(flush_beat);
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #(DRIVE_DELAY);  // drive and sample away from the edge
    endtask

    task automatic check_idle(input logic got, input string name);
        if (got !== 1'b0) begin
            report_failure($sformatf("[ERROR] %0t: %s is %b after reset, expected 0",
                $time, name, got));
        end
    endtask

    task automatic check_addr(input block_buffer_pkg::block_addr_t got,
                              input block_buffer_pkg::block_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t: write acked address %0d, expected %0d",
                $time, got, exp));
        end
    endtask

    task automatic check_rsp(input block_buffer_pkg::read_rsp_t got,
                             input block_buffer_pkg::read_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "[ERROR] %0t: read got data %h addr %0d last %b, expected %h %0d %b",
                $time, got.data, got.addr, got.last, exp.data, exp.addr, exp.last));
        end
    endtask

    task automatic check_beat(input block_buffer_pkg::flush_beat_t got,
                              input block_buffer_pkg::flush_beat_t exp, input int idx);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t: flush beat %0d got %h @%0d, expected %h @%0d",
                $time, idx, got.data, got.addr, exp.data, exp.addr));
        end
    endtask

    task automatic write_handshake(input block_buffer_pkg::block_t data,
                                   output block_buffer_pkg::block_addr_t addr);
        next_cycle();
        wr_data = data;
        wr_req  = 1'b1;
        while (wr_ack !== 1'b1) next_cycle();
        addr   = wr_addr;  // held stable while ack is high
        wr_req = 1'b0;
        while (wr_ack !== 1'b0) next_cycle();
    endtask

    task automatic read_handshake(output block_buffer_pkg::read_rsp_t rsp);
        next_cycle();
        rd_req = 1'b1;
        while (rd_ack !== 1'b1) next_cycle();
        rsp    = rd_rsp;
        rd_req = 1'b0;
        while (rd_ack !== 1'b0) next_cycle();
    endtask

    task automatic flush_handshake(output int beats_at_ack);
        next_cycle();
        fl_req = 1'b1;
        while (fl_ack !== 1'b1) next_cycle();
        beats_at_ack = beats.size();  // whole stream must be out before ack
        fl_req = 1'b0;
        while (fl_ack !== 1'b0) next_cycle();
    endtask

    task automatic run_op(input op_kind_t kind, input block_buffer_pkg::block_t data);
        block_buffer_pkg::block_addr_t got_addr;
        block_buffer_pkg::read_rsp_t   got_rsp;
        block_buffer_pkg::read_rsp_t   exp_rsp;
        block_buffer_pkg::flush_beat_t exp_beat;
        int                            seen;
        case (kind)
            OP_WRITE: begin
                write_handshake(data, got_addr);
                check_addr(got_addr, model_wr_ptr);
                model_mem[model_wr_ptr] = data;
                model_wr_ptr = block_buffer_pkg::block_addr_t'(
                    (model_wr_ptr + 1) % block_buffer_pkg::NUM_BLOCKS);
            end
            OP_READ: begin
                read_handshake(got_rsp);
                exp_rsp.data = model_mem[model_rd_ptr];
                exp_rsp.addr = model_rd_ptr;
                exp_rsp.last = (model_rd_ptr ==
                    block_buffer_pkg::block_addr_t'(block_buffer_pkg::NUM_BLOCKS - 1));
                check_rsp(got_rsp, exp_rsp);
                model_rd_ptr = block_buffer_pkg::block_addr_t'(
                    (model_rd_ptr + 1) % block_buffer_pkg::NUM_BLOCKS);
            end
            default: begin
                if (beats.size() != 0) begin
                    report_failure("flush data appeared while no flush was running");
                end
                flush_handshake(seen);
                if (seen != block_buffer_pkg::NUM_BLOCKS) begin
                    report_failure($sformatf("flush ack came after %0d beats instead of %0d",
                        seen, block_buffer_pkg::NUM_BLOCKS));
                end
                for (int i = 0; i < block_buffer_pkg::NUM_BLOCKS; i++) begin
                    exp_beat.data = model_mem[i];
                    exp_beat.addr = block_buffer_pkg::block_addr_t'(i);
                    check_beat(beats.pop_front(), exp_beat, i);
                end
                model_rd_ptr = '0;  // flush leaves the read pointer at 0
            end
        endcase
    endtask

    // watchdog whose budget scales with the number of operations
    initial begin
        int limit_cycles;
        limit_cycles = RESET_CYCLES + NUM_RANDOM * CYCLES_PER_OP;
        for (int row = 0; row < NUM_ROWS; row++) begin
            limit_cycles += op_table[row].count * CYCLES_PER_OP;
        end
        repeat (limit_cycles) @(posedge clk_in);
        report_failure($sformatf("watchdog expired after %0d cycles, a handshake never finished",
            limit_cycles));
    end

    initial begin
        block_buffer_pkg::block_addr_t exp_ptr;
        int unsigned                   pick;
        void'($urandom(SEED));
        rst_in       = 1'b1;
        wr_req       = 1'b0;
        wr_data      = '0;
        rd_req       = 1'b0;
        fl_req       = 1'b0;
        model_wr_ptr = '0;
        model_rd_ptr = '0;
        for (int i = 0; i < block_buffer_pkg::NUM_BLOCKS; i++) begin
            model_mem[i] = '0;  // RAM powers up zeroed
        end

        repeat (RESET_CYCLES) @(posedge clk_in);
        #(DRIVE_DELAY);
        rst_in = 1'b0;
        next_cycle();
        check_idle(wr_ack, "wr_ack");
        check_idle(rd_ack, "rd_ack");
        check_idle(fl_ack, "fl_ack");
        check_idle(flush_valid, "flush_valid");

        for (int row = 0; row < NUM_ROWS; row++) begin
            exp_ptr = (op_table[row].kind == OP_WRITE) ? model_wr_ptr : model_rd_ptr;
            if (op_table[row].kind != OP_FLUSH && op_table[row].first_addr != exp_ptr) begin
                report_failure($sformatf("table row %0d starts at address %0d, model is at %0d",
                    row, op_table[row].first_addr, exp_ptr));
            end
            for (int n = 0; n < op_table[row].count; n++) begin
                run_op(op_table[row].kind, op_table[row].data + n);
            end
        end

        // random mix with a flush about one time in sixteen
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick = $urandom_range(15, 0);
            if (pick == 0) begin
                run_op(OP_FLUSH, '0);
            end else if (pick < 8) begin
                run_op(OP_WRITE, $urandom());
            end else begin
                run_op(OP_READ, '0);
            end
        end

        next_cycle();
        if (beats.size() != 0) begin
            report_failure("flush data appeared after the last flush had finished");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/block_buffer_pkg.sv
`default_nettype none

package block_buffer_pkg;

    localparam int BLOCK_W     = 32;
    localparam int NUM_BLOCKS  = 16;
    localparam int ADDR_W      = $clog2(NUM_BLOCKS);
    localparam int RAM_LATENCY = 2;  // read pulse to data out

    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [ADDR_W-1:0]  block_addr_t;

    // final entry of the RAM, where both pointers wrap
    localparam block_addr_t LAST_ADDR = block_addr_t'(NUM_BLOCKS - 1);

    typedef struct packed {
        block_t      data;
        block_addr_t addr;
        logic        last;  // addr is the final entry
    } read_rsp_t;

    typedef struct packed {
        block_t      data;
        block_addr_t addr;
    } flush_beat_t;

endpackage

`default_nettype wire

//--- hw/block_buffer_top.sv
`default_nettype none

module block_buffer_top (
    input  wire                                clk_in,
    input  wire                                rst_in,
    // write channel
    input  wire                                wr_req,
    input  wire block_buffer_pkg::block_t      wr_data,
    output logic                               wr_ack,
    output block_buffer_pkg::block_addr_t      wr_addr,
    // read channel
    input  wire                                rd_req,
    output logic                               rd_ack,
    output block_buffer_pkg::read_rsp_t        rd_rsp,
    // flush channel and stream
    input  wire                                fl_req,
    output logic                               fl_ack,
    output logic                               flush_valid,
    output block_buffer_pkg::flush_beat_t      flush_beat
);

    logic                           wr_pulse, wr_rsp_valid;
    block_buffer_pkg::block_t       wr_cmd;
    block_buffer_pkg::block_addr_t  wr_rsp;
    logic                           rd_pulse, rd_rsp_valid, read_ready;
    block_buffer_pkg::read_rsp_t    rd_rsp_int;
    logic                           fl_pulse, fl_rsp_valid;

    req_ack_slave #(
        .cmd_t (block_buffer_pkg::block_t),
        .rsp_t (block_buffer_pkg::block_addr_t)
    ) wr_slave (
        .clk_in (clk_in), .rst_in (rst_in),
        .req (wr_req), .cmd_in (wr_data), .ack (wr_ack), .rsp_out (wr_addr),
        .ready (1'b1), .cmd_pulse (wr_pulse), .cmd (wr_cmd),
        .rsp_valid (wr_rsp_valid), .rsp (wr_rsp)
    );

    // read carries no request payload
    req_ack_slave #(
        .cmd_t (logic),
        .rsp_t (block_buffer_pkg::read_rsp_t)
    ) rd_slave (
        .clk_in (clk_in), .rst_in (rst_in),
        .req (rd_req), .cmd_in (1'b0), .ack (rd_ack), .rsp_out (rd_rsp),
        .ready (read_ready), .cmd_pulse (rd_pulse), .cmd (),
        .rsp_valid (rd_rsp_valid), .rsp (rd_rsp_int)
    );

    req_ack_slave #(.cmd_t(logic), .rsp_t(logic)) fl_slave (
        .clk_in (clk_in), .rst_in (rst_in),
        .req (fl_req), .cmd_in (1'b0), .ack (fl_ack), .rsp_out (),
        .ready (1'b1), .cmd_pulse (fl_pulse), .cmd (),
        .rsp_valid (fl_rsp_valid), .rsp (1'b1)
    );

    block_store store (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .wr_pulse     (wr_pulse),
        .wr_data      (wr_cmd),
        .wr_rsp_valid (wr_rsp_valid),
        .wr_rsp       (wr_rsp),
        .rd_pulse     (rd_pulse),
        .read_ready   (read_ready),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp       (rd_rsp_int),
        .fl_pulse     (fl_pulse),
        .fl_rsp_valid (fl_rsp_valid),
        .flush_valid  (flush_valid),
        .flush_beat   (flush_beat)
    );

endmodule

`default_nettype wire

//--- hw/block_ram.sv
`default_nettype none

// simple dual-port RAM
// port A reads (read-first, output register), port B writes
module block_ram (
    input  wire                             clk_in,
    input  wire block_buffer_pkg::block_addr_t rd_addr,
    output block_buffer_pkg::block_t        rd_data,
    input  wire                             wr_en,
    input  wire block_buffer_pkg::block_addr_t wr_addr,
    input  wire block_buffer_pkg::block_t   wr_data
);

    block_buffer_pkg::block_t mem [block_buffer_pkg::NUM_BLOCKS];
    block_buffer_pkg::block_t rd_q;  // array read stage

    initial begin
        for (int i = 0; i < block_buffer_pkg::NUM_BLOCKS; i++) begin
            mem[i] = '0;
        end
    end

    // port B
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // port A, old contents win on a same-address collision
    always_ff @(posedge clk_in) begin
        rd_q    <= mem[rd_addr];
        rd_data <= rd_q;  // output register, second cycle of latency
    end

endmodule

`default_nettype wire

//--- hw/block_store.sv
`default_nettype none

module block_store (
    input  wire                                clk_in,
    input  wire                                rst_in,
    // write side
    input  wire                                wr_pulse,
    input  wire block_buffer_pkg::block_t      wr_data,
    output logic                               wr_rsp_valid,
    output block_buffer_pkg::block_addr_t      wr_rsp,
    // read side
    input  wire                                rd_pulse,
    output logic                               read_ready,
    output logic                               rd_rsp_valid,
    output block_buffer_pkg::read_rsp_t        rd_rsp,
    // flush
    input  wire                                fl_pulse,
    output logic                               fl_rsp_valid,
    output logic                               flush_valid,
    output block_buffer_pkg::flush_beat_t      flush_beat
);

    typedef enum logic [1:0] {IDLE, SHIFTING, FLUSHING} flush_state_t;

    flush_state_t state, state_nxt;

    block_buffer_pkg::block_addr_t rd_ptr;
    block_buffer_pkg::block_addr_t wr_ptr;
    block_buffer_pkg::block_addr_t fl_cnt;    // beats issued in FLUSHING
    block_buffer_pkg::block_addr_t rd_addr_q; // rd_ptr aligned to RAM output
    block_buffer_pkg::block_t      ram_rd_data;

    logic force_read;
    logic fl_done;
    logic rd_last_q;

    assign force_read = (state != IDLE);  // step the read pointer every cycle of a flush
    assign fl_done    = (state == FLUSHING) && (fl_cnt == block_buffer_pkg::LAST_ADDR);

    evt_counter #(.MAX_COUNT(block_buffer_pkg::NUM_BLOCKS)) rd_ptr_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt    (rd_pulse || force_read),
        .count  (rd_ptr)
    );

    evt_counter #(.MAX_COUNT(block_buffer_pkg::NUM_BLOCKS)) wr_ptr_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt    (wr_pulse),
        .count  (wr_ptr)
    );

    evt_counter #(.MAX_COUNT(block_buffer_pkg::NUM_BLOCKS)) fl_beat_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt    (state == FLUSHING),
        .count  (fl_cnt)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (fl_pulse) state_nxt = SHIFTING;
            // the pointer wraps to 0 on the same edge
            SHIFTING: if (rd_ptr == block_buffer_pkg::LAST_ADDR) state_nxt = FLUSHING;
            FLUSHING: if (fl_done) state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state        <= IDLE;
            read_ready   <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end else begin
            state        <= state_nxt;
            read_ready   <= (state_nxt == IDLE);
            wr_rsp_valid <= wr_pulse;
        end
    end

    always_ff @(posedge clk_in) begin
        if (wr_pulse) begin
            wr_rsp <= wr_ptr;  // address just written
        end
    end

    block_ram ram (
        .clk_in  (clk_in),
        .rd_addr (rd_ptr),
        .rd_data (ram_rd_data),
        .wr_en   (wr_pulse),
        .wr_addr (wr_ptr),
        .wr_data (wr_data)
    );

    // everything below lines up with the RAM output
    pipeliner #(.data_t(logic), .STAGES(block_buffer_pkg::RAM_LATENCY)) rd_valid_pipe (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (rd_pulse),
        .data_out (rd_rsp_valid)
    );

    pipeliner #(.data_t(logic), .STAGES(block_buffer_pkg::RAM_LATENCY)) fl_valid_pipe (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (state == FLUSHING),
        .data_out (flush_valid)
    );

    pipeliner #(
        .data_t (block_buffer_pkg::block_addr_t),
        .STAGES (block_buffer_pkg::RAM_LATENCY)
    ) addr_pipe (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (rd_ptr),
        .data_out (rd_addr_q)
    );

    pipeliner #(.data_t(logic), .STAGES(block_buffer_pkg::RAM_LATENCY)) last_pipe (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (rd_ptr == block_buffer_pkg::LAST_ADDR),
        .data_out (rd_last_q)
    );

    // flush response lands together with the final beat
    pipeliner #(.data_t(logic), .STAGES(block_buffer_pkg::RAM_LATENCY)) fl_done_pipe (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (fl_done),
        .data_out (fl_rsp_valid)
    );

    assign rd_rsp     = '{data: ram_rd_data, addr: rd_addr_q, last: rd_last_q};
    assign flush_beat = '{data: ram_rd_data, addr: rd_addr_q};

    // read slave must hold off while read_ready is low
    a_rd_only_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        rd_pulse |-> state == IDLE);

    a_fl_only_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        fl_pulse |-> state == IDLE);

endmodule

`default_nettype wire

//--- hw/evt_counter.sv
`default_nettype none

// counts single-cycle events and wraps back to zero at MAX_COUNT
module evt_counter #(
    parameter int MAX_COUNT = 16
) (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire                          evt,
    output block_buffer_pkg::block_addr_t count
);

    localparam block_buffer_pkg::block_addr_t WRAP_AT =
        block_buffer_pkg::block_addr_t'(MAX_COUNT - 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= '0;
        end else if (evt) begin
            if (count == WRAP_AT) begin
                count <= '0;  // modulo wrap
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    initial begin
        assert (MAX_COUNT >= 2 && MAX_COUNT <= 2 ** block_buffer_pkg::ADDR_W)
            else $error("evt_counter MAX_COUNT %0d does not fit the address", MAX_COUNT);
    end

endmodule

`default_nettype wire

//--- hw/pipeliner.sv
`default_nettype none

// fixed-depth delay line, any packed payload
module pipeliner #(
    parameter type data_t = logic,
    parameter int  STAGES = 2
) (
    input  wire   clk_in,
    input  wire   rst_in,
    input  wire   data_t data_in,
    output data_t data_out
);

    data_t pipe [STAGES];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= data_in;
            for (int i = 1; i < STAGES; i++) begin
                pipe[i] <= pipe[i-1];  // shift one stage per clock
            end
        end
    end

    assign data_out = pipe[STAGES-1];

    initial begin
        assert (STAGES >= 1) else $error("pipeliner needs at least one stage");
    end

endmodule

`default_nettype wire

//--- hw/req_ack_slave.sv
`default_nettype none

// four-phase req/ack front end
// turns one handshake into a single command pulse and waits for its response
module req_ack_slave #(
    parameter type cmd_t = logic,
    parameter type rsp_t = logic
) (
    input  wire  clk_in,
    input  wire  rst_in,
    // handshake side
    input  wire  req,
    input  wire  cmd_t cmd_in,
    output logic ack,
    output rsp_t rsp_out,
    // store side
    input  wire  ready,
    output logic cmd_pulse,
    output cmd_t cmd,
    input  wire  rsp_valid,
    input  wire  rsp_t rsp
);

    typedef enum logic [2:0] {
        WAIT_REQ,
        ISSUE,
        WAIT_RSP,
        HOLD_ACK,
        WAIT_DROP
    } phase_t;

    phase_t state;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= WAIT_REQ;
        end else begin
            case (state)
                WAIT_REQ:  if (req) state <= ISSUE;
                ISSUE:     if (ready) state <= WAIT_RSP;  // stall here until the store can take it
                WAIT_RSP:  if (rsp_valid) state <= HOLD_ACK;
                HOLD_ACK:  if (!req) state <= WAIT_DROP;
                WAIT_DROP: state <= WAIT_REQ;  // ack is low, one idle cycle before next req
                default:   state <= WAIT_REQ;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk_in) begin
        if (state == WAIT_REQ && req) begin
            cmd <= cmd_in;
        end
        if (state == WAIT_RSP && rsp_valid) begin
            rsp_out <= rsp;  // held stable for the whole ack phase
        end
    end

    assign cmd_pulse = (state == ISSUE) && ready;
    assign ack       = (state == HOLD_ACK);

    // a response with no command outstanding would be lost
    a_rsp_when_waiting: assert property (@(posedge clk_in) disable iff (rst_in)
        rsp_valid |-> state == WAIT_RSP);

endmodule

`default_nettype wire
